//--- seg_snake_pkg.sv
package seg_snake_pkg;

    localparam int NUM_SEGS = 7;

    // Consecutive high samples before a button counts as pressed
    localparam int DEBOUNCE_DEPTH = 4;

    // Kept short so a simulation covers several ticks quickly
    localparam int TICK_CYCLES = 16;

    localparam int START_TICKS = 3;
    localparam int FALL_TICKS = 1;

    localparam int TICK_CNT_W = $clog2(TICK_CYCLES);

    // Sized for the longer of the two phase waits
    localparam int PHASE_CNT_W =
        $clog2((START_TICKS > FALL_TICKS ? START_TICKS : FALL_TICKS) + 1);

    // Bit n of the segment outputs belongs to index n
    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_idx_t;

    typedef enum logic [1:0] {
        RIGHT = 2'd0,
        LEFT  = 2'd1,
        UP    = 2'd2,
        DOWN  = 2'd3
    } heading_t;

    typedef enum logic [1:0] {
        MODE_INITIAL = 2'd0,
        MODE_MOVING  = 2'd1,
        MODE_FALLING = 2'd2
    } game_mode_t;

    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } btn_pulse_t;

    // remain bit set = segment not yet cleared
    typedef struct packed {
        seg_idx_t              pos;
        heading_t              head;
        logic [NUM_SEGS-1:0]   remain;
    } walk_t;

    localparam walk_t WALK_START = '{pos: SEG_G, head: LEFT, remain: '1};

endpackage

//--- btn_conditioner.sv
module btn_conditioner (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [3:0]                btn_raw,
    output seg_snake_pkg::btn_pulse_t pulses
);

    import seg_snake_pkg::*;

    logic [DEBOUNCE_DEPTH-1:0] shift [4];
    logic [3:0] level;
    logic [3:0] level_q;

    // Pressed only once the whole window is high
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            level[i] = &shift[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                shift[i] <= '0;
            end
            level_q <= '0;
            pulses <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                shift[i] <= {shift[i][DEBOUNCE_DEPTH-2:0], btn_raw[i]};
            end
            level_q <= level;
            // Rising edge of the debounced level
            pulses <= btn_pulse_t'(level & ~level_q);
        end
    end

endmodule

//--- tick_gen.sv
module tick_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    import seg_snake_pkg::*;

    logic [TICK_CNT_W-1:0] cnt;

    // Game time base as an enable instead of a divided clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            tick <= 1'b0;
        end else if (cnt == TICK_CNT_W'(TICK_CYCLES - 1)) begin
            cnt <= '0;
            tick <= 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

//--- game_fsm.sv
module game_fsm (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                tick,
    input  seg_snake_pkg::btn_pulse_t           pulses,
    input  logic [seg_snake_pkg::NUM_SEGS-1:0]  remain,
    output seg_snake_pkg::game_mode_t           mode
);

    import seg_snake_pkg::*;

    logic [PHASE_CNT_W-1:0] tick_cnt;
    logic rec_empty;

    // Empty only once all seven bits are clear
    assign rec_empty = (remain == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= MODE_INITIAL;
            tick_cnt <= '0;
        end else begin
            case (mode)
                MODE_INITIAL: begin
                    if (tick) begin
                        if (tick_cnt == PHASE_CNT_W'(START_TICKS - 1)) begin
                            mode <= MODE_MOVING;
                            tick_cnt <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                MODE_MOVING: begin
                    tick_cnt <= '0;
                    if (pulses.down) begin
                        mode <= MODE_FALLING;
                    end
                end
                MODE_FALLING: begin
                    // Fall wait only runs once every segment is gone
                    if (!rec_empty) begin
                        tick_cnt <= '0;
                    end else if (tick) begin
                        if (tick_cnt == PHASE_CNT_W'(FALL_TICKS - 1)) begin
                            mode <= MODE_INITIAL;
                            tick_cnt <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    mode <= MODE_INITIAL;
                    tick_cnt <= '0;
                end
            endcase
        end
    end

endmodule

//--- segment_walker.sv
module segment_walker (
    input  logic                       clk,
    input  logic                       rst,
    input  seg_snake_pkg::game_mode_t  mode,
    input  seg_snake_pkg::btn_pulse_t  pulses,
    output seg_snake_pkg::walk_t       walk
);

    import seg_snake_pkg::*;

    typedef struct packed {
        seg_idx_t pos;
        heading_t head;
    } step_t;

    step_t nxt;
    heading_t hd;

    assign hd = walk.head;

    // Move table where the first matching row wins and down never moves
    always_comb begin
        nxt = '{walk.pos, walk.head};
        case (walk.pos)
            SEG_A: begin
                if (hd == RIGHT && pulses.right) nxt = '{SEG_B, DOWN};
                else if (hd == LEFT && pulses.left) nxt = '{SEG_F, DOWN};
            end
            SEG_B: begin
                if (hd == UP && pulses.left) nxt = '{SEG_A, LEFT};
                else if (hd == DOWN && pulses.right) nxt = '{SEG_G, LEFT};
                else if (hd == DOWN && pulses.up) nxt = '{SEG_C, DOWN};
            end
            SEG_C: begin
                if (hd == UP && pulses.left) nxt = '{SEG_G, LEFT};
                else if (hd == UP && pulses.up) nxt = '{SEG_B, UP};
                else if (hd == DOWN && pulses.right) nxt = '{SEG_D, DOWN};
            end
            SEG_D: begin
                if (hd == RIGHT && pulses.left) nxt = '{SEG_C, UP};
                else if (hd == LEFT && pulses.right) nxt = '{SEG_E, UP};
            end
            SEG_E: begin
                if (hd == UP && pulses.right) nxt = '{SEG_G, RIGHT};
                else if (hd == UP && pulses.up) nxt = '{SEG_F, UP};
                else if (hd == DOWN && pulses.left) nxt = '{SEG_D, RIGHT};
            end
            SEG_F: begin
                if (hd == UP && pulses.right) nxt = '{SEG_A, RIGHT};
                else if (hd == DOWN && pulses.left) nxt = '{SEG_G, RIGHT};
            end
            SEG_G: begin
                if (hd == RIGHT && pulses.left) nxt = '{SEG_B, UP};
                else if (hd == RIGHT && pulses.right) nxt = '{SEG_C, DOWN};
                else if (hd == LEFT && pulses.left) nxt = '{SEG_E, DOWN};
                else if (hd == LEFT && pulses.right) nxt = '{SEG_F, UP};
            end
            default: begin
                nxt = '{SEG_G, LEFT};
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            walk <= WALK_START;
        end else if (mode == MODE_INITIAL) begin
            // Start position and a full record for the next round
            walk <= WALK_START;
        end else begin
            walk.pos <= nxt.pos;
            walk.head <= nxt.head;
            // Clear wherever the walker currently sits
            if (mode == MODE_FALLING) begin
                walk.remain[walk.pos] <= 1'b0;
            end
        end
    end

endmodule

//--- seg_display.sv
module seg_display (
    input  logic                                clk,
    input  logic                                rst,
    input  seg_snake_pkg::game_mode_t           mode,
    input  seg_snake_pkg::walk_t                walk,
    output logic [seg_snake_pkg::NUM_SEGS-1:0]  seg_n
);

    import seg_snake_pkg::*;

    logic [NUM_SEGS-1:0] lit;

    always_comb begin
        lit = '0;
        case (mode)
            MODE_INITIAL: lit[SEG_G] = 1'b1;
            MODE_MOVING: lit[walk.pos] = 1'b1;
            // Steady view of the segments still left
            MODE_FALLING: lit = walk.remain;
            default: lit = '0;
        endcase
    end

    // Active low segments are blank out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_n <= '1;
        end else begin
            seg_n <= ~lit;
        end
    end

endmodule

//--- seg_snake_top.sv
module seg_snake_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [3:0]                 btn_raw,
    output logic [6:0]                 seg_n,
    output seg_snake_pkg::game_mode_t  mode
);

    import seg_snake_pkg::*;

    btn_pulse_t pulses;
    walk_t walk;
    logic tick;

    btn_conditioner u_btn (
        .clk     (clk),
        .rst     (rst),
        .btn_raw (btn_raw),
        .pulses  (pulses)
    );

    tick_gen u_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    game_fsm u_fsm (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .pulses (pulses),
        .remain (walk.remain),
        .mode   (mode)
    );

    segment_walker u_walker (
        .clk    (clk),
        .rst    (rst),
        .mode   (mode),
        .pulses (pulses),
        .walk   (walk)
    );

    seg_display u_disp (
        .clk   (clk),
        .rst   (rst),
        .mode  (mode),
        .walk  (walk),
        .seg_n (seg_n)
    );

endmodule

//--- seg_snake_asserts.sv
module seg_snake_asserts (
    input  logic                       clk,
    input  logic                       rst,
    input  seg_snake_pkg::game_mode_t  mode,
    input  logic [6:0]                 seg_n
);
    timeunit 1ns;
    timeprecision 1ps;

    import seg_snake_pkg::*;

    int fail_legal = 0;
    int fail_onehot = 0;
    int fail_jump = 0;
    int fail_cnt;

    assign fail_cnt = fail_legal + fail_onehot + fail_jump;

    mode_legal: assert property (@(posedge clk) disable iff (rst)
        mode == MODE_INITIAL || mode == MODE_MOVING || mode == MODE_FALLING)
    else begin
        fail_legal = fail_legal + 1;
        $error("mode holds an undefined encoding %0d", mode);
    end

    // Exactly one segment lit while steering
    moving_one_lit: assert property (@(posedge clk) disable iff (rst)
        mode == MODE_MOVING |-> $countones(~seg_n) == 1)
    else begin
        fail_onehot = fail_onehot + 1;
        $error("seg_n %h lights other than one segment in MOVING", seg_n);
    end

    no_initial_to_falling: assert property (@(posedge clk) disable iff (rst)
        mode == MODE_INITIAL |=> mode != MODE_FALLING)
    else begin
        fail_jump = fail_jump + 1;
        $error("mode went from INITIAL straight to FALLING");
    end

endmodule

bind seg_snake_top seg_snake_asserts u_asserts (
    .clk   (clk),
    .rst   (rst),
    .mode  (mode),
    .seg_n (seg_n)
);

//--- tb_seg_snake.sv
module tb_seg_snake;
    timeunit 1ns;
    timeprecision 1ps;

    import seg_snake_pkg::*;

    logic clk = 1'b0;
    logic rst;
    logic [3:0] btn_raw;
    logic [6:0] seg_n;
    game_mode_t mode;

    // Expected game state advanced press by press
    game_mode_t m_mode;
    seg_idx_t m_pos;
    heading_t m_head;
    logic [NUM_SEGS-1:0] m_remain;

    integer seed;
    int n_checks = 0;
    int n_errors = 0;
    int n_presses = 56;
    event do_compare;

    seg_snake_top uut (
        .clk     (clk),
        .rst     (rst),
        .btn_raw (btn_raw),
        .seg_n   (seg_n),
        .mode    (mode)
    );

    always #50 clk = ~clk;

    // Returns {position, heading} after one button pulse
    function automatic logic [4:0] ref_step(seg_idx_t pos, heading_t head, heading_t btn);
        logic [4:0] r;
        case ({pos, head, btn})
            {SEG_A, RIGHT, RIGHT}: r = {SEG_B, DOWN};
            {SEG_A, LEFT, LEFT}:   r = {SEG_F, DOWN};
            {SEG_B, UP, LEFT}:     r = {SEG_A, LEFT};
            {SEG_B, DOWN, RIGHT}:  r = {SEG_G, LEFT};
            {SEG_B, DOWN, UP}:     r = {SEG_C, DOWN};
            {SEG_C, UP, LEFT}:     r = {SEG_G, LEFT};
            {SEG_C, UP, UP}:       r = {SEG_B, UP};
            {SEG_C, DOWN, RIGHT}:  r = {SEG_D, DOWN};
            {SEG_D, RIGHT, LEFT}:  r = {SEG_C, UP};
            {SEG_D, LEFT, RIGHT}:  r = {SEG_E, UP};
            {SEG_E, UP, RIGHT}:    r = {SEG_G, RIGHT};
            {SEG_E, UP, UP}:       r = {SEG_F, UP};
            {SEG_E, DOWN, LEFT}:   r = {SEG_D, RIGHT};
            {SEG_F, UP, RIGHT}:    r = {SEG_A, RIGHT};
            {SEG_F, DOWN, LEFT}:   r = {SEG_G, RIGHT};
            {SEG_G, RIGHT, LEFT}:  r = {SEG_B, UP};
            {SEG_G, RIGHT, RIGHT}: r = {SEG_C, DOWN};
            {SEG_G, LEFT, LEFT}:   r = {SEG_E, DOWN};
            {SEG_G, LEFT, RIGHT}:  r = {SEG_F, UP};
            default:               r = {pos, head};
        endcase
        return r;
    endfunction

    function automatic logic [NUM_SEGS-1:0] ref_seg(game_mode_t m, seg_idx_t pos,
                                                    logic [NUM_SEGS-1:0] remain);
        logic [NUM_SEGS-1:0] lit;
        case (m)
            MODE_INITIAL: lit = NUM_SEGS'(1) << SEG_G;
            MODE_MOVING: lit = NUM_SEGS'(1) << pos;
            MODE_FALLING: lit = remain;
            default: lit = '0;
        endcase
        return ~lit;
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    always begin
        @(do_compare);
        compare_value("seg_n", 32'(seg_n), 32'(ref_seg(m_mode, m_pos, m_remain)));
        compare_value("mode", 32'(mode), 32'(m_mode));
    end

    task automatic reset_model();
        m_mode = MODE_INITIAL;
        m_pos = SEG_G;
        m_head = LEFT;
        m_remain = '1;
    endtask

    // Bit 3 is right, bit 0 is down
    task automatic press(heading_t btn);
        logic [4:0] nxt;
        btn_raw = 4'b1000 >> btn;
        repeat (DEBOUNCE_DEPTH + 2) @(negedge clk);
        btn_raw = 4'b0000;
        repeat (DEBOUNCE_DEPTH + 5) @(negedge clk);
        nxt = ref_step(m_pos, m_head, btn);
        m_pos = seg_idx_t'(nxt[4:2]);
        m_head = heading_t'(nxt[1:0]);
        if (m_mode == MODE_FALLING) begin
            m_remain[m_pos] = 1'b0;
        end
    endtask

    task automatic short_blip(heading_t btn);
        btn_raw = 4'b1000 >> btn;
        repeat (DEBOUNCE_DEPTH - 1) @(negedge clk);
        btn_raw = 4'b0000;
        repeat (DEBOUNCE_DEPTH + 8) @(negedge clk);
    endtask

    task automatic wait_mode(game_mode_t target, int limit);
        int n;
        n = 0;
        while (mode != target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (mode != target) begin
            n_errors++;
            $display("Timeout: mode did not reach %s within %0d cycles", target.name(), limit);
        end
        // One more cycle for the registered display
        @(negedge clk);
    endtask

    initial begin
        heading_t btn;
        heading_t path [6];
        logic [31:0] r;
        seed = 32'h556a;
        rst = 1'b1;
        btn_raw = 4'b0000;
        path = '{LEFT, LEFT, LEFT, UP, LEFT, LEFT};
        reset_model();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        -> do_compare;
        wait_mode(MODE_MOVING, START_TICKS * TICK_CYCLES + 2);
        m_mode = MODE_MOVING;
        -> do_compare;
        // G heading left has no row for up
        press(UP);
        -> do_compare;
        short_blip(LEFT);
        -> do_compare;
        press(DOWN);
        m_mode = MODE_FALLING;
        m_remain[m_pos] = 1'b0;
        -> do_compare;
        // Visits E, D, C, B, A, F; the last step empties the record
        for (int i = 0; i < 6; i++) begin
            press(path[i]);
            if (m_remain != '0) begin
                -> do_compare;
            end
        end
        wait_mode(MODE_INITIAL, (FALL_TICKS + 1) * TICK_CYCLES + 2);
        reset_model();
        -> do_compare;
        // Down before the game starts must not start the fall
        press(DOWN);
        -> do_compare;
        wait_mode(MODE_MOVING, START_TICKS * TICK_CYCLES + 2);
        m_mode = MODE_MOVING;
        -> do_compare;
        for (int i = 0; i < 40; i++) begin
            r = $unsigned($random(seed)) % 32'd3;
            btn = heading_t'(r[1:0]);
            press(btn);
            -> do_compare;
        end
        press(DOWN);
        m_mode = MODE_FALLING;
        m_remain[m_pos] = 1'b0;
        -> do_compare;
        // Too few moves to clear all seven segments
        for (int i = 0; i < 5; i++) begin
            r = $unsigned($random(seed)) % 32'd3;
            btn = heading_t'(r[1:0]);
            press(btn);
            -> do_compare;
        end
        @(negedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, uut.u_asserts.fail_cnt);
        if (n_errors == 0 && uut.u_asserts.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = n_presses * (2 * DEBOUNCE_DEPTH + 7)
                + 4 * (START_TICKS + FALL_TICKS + 1) * TICK_CYCLES;
        limit = 2 * limit;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", limit);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- seg_snake.f
seg_snake_pkg.sv
btn_conditioner.sv
tick_gen.sv
game_fsm.sv
segment_walker.sv
seg_display.sv
seg_snake_top.sv
seg_snake_asserts.sv
tb_seg_snake.sv

//--- run.sh
#!/bin/sh
# Build and run the seg_snake testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f seg_snake.f --top-module tb_seg_snake -o sim_seg_snake
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_seg_snake +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1
